// File: common/game_pkg.sv
// Game-side codes and field types shared by the link top level, the controller and the testbench
`default_nettype none

package game_pkg;

    // ==================================================
    // Game phase codes
    // ==================================================

    // Phase code as produced by the game logic
    typedef logic [2:0] game_state_t;

    localparam game_state_t state_start   = 3'd0;
    localparam game_state_t state_select  = 3'd1;
    localparam game_state_t state_loading = 3'd2;
    localparam game_state_t state_running = 3'd3;
    localparam game_state_t state_victory = 3'd5;
    localparam game_state_t state_defeat  = 3'd6;

    // ==================================================
    // Board and progress fields
    // ==================================================

    // 9x9 grid
    localparam int board_cells = 81;
    localparam int digit_width = 4;
    localparam int color_width = 2;

    // One digit per cell, cell 0 in the low bits
    typedef logic [board_cells*digit_width-1:0] board_t;

    // One color code per cell
    typedef logic [board_cells*color_width-1:0] colors_t;

    // Cursor, x in the upper nibble and y in the lower
    typedef logic [7:0] position_t;

    typedef logic [6:0]  score_t;
    typedef logic [10:0] seconds_t;

endpackage

`default_nettype wire

// File: common/link_pkg.sv
// Link-side byte type, frame identifiers and payload sizes used by the senders and the testbench
`default_nettype none

package link_pkg;

    // One byte on the UART port
    typedef logic [7:0] link_byte_t;

    // ==================================================
    // Frame identifiers
    // ==================================================
    localparam link_byte_t frame_id_setup  = 8'hA1;
    localparam link_byte_t frame_id_status = 8'hA2;
    localparam link_byte_t frame_id_end    = 8'hA3;

    // ==================================================
    // Payload sizes in bytes
    // ==================================================

    // Difficulty byte, then the board padded to 41 bytes
    localparam int setup_bytes = 42;

    // Colors padded to 21 bytes, position, then errors and selected number
    localparam int status_bytes = 23;

    // Victory and score, then seconds padded to 2 bytes
    localparam int end_bytes = 3;

endpackage

`default_nettype wire

// File: common/frame_if.sv
// Strobe and byte bundle between the link controller and one frame sender
`timescale 1ns/1ns
`default_nettype none

interface frame_if;
    import link_pkg::*;

    // One-cycle start pulse from the controller
    logic send;

    // One-cycle pulse after the checksum byte went out
    logic done;

    // Byte port request toward the UART
    logic       tx_start;
    link_byte_t tx_data;

    modport ctrl (
        output send,
        input  done,
        input  tx_start,
        input  tx_data
    );

    modport sender (
        input  send,
        output done,
        output tx_start,
        output tx_data
    );

endinterface

`default_nettype wire

// File: hw/frame_sender/frame_sender.sv
// Serializes one frame (identifier, payload MSB first, XOR checksum) onto the UART byte port
`timescale 1ns/1ns
`default_nettype none

module frame_sender #(
    parameter link_pkg::link_byte_t FRAME_ID = 8'h00,
    parameter int PAYLOAD_BYTES = 1
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       uart_busy,
    input  logic [PAYLOAD_BYTES*8-1:0] payload,
    frame_if.sender                    port
);
    import link_pkg::*;

    localparam int payload_width = PAYLOAD_BYTES * 8;
    localparam int count_width = $clog2(PAYLOAD_BYTES + 2);

    // Byte index of the checksum, identifier is index 0
    localparam logic [count_width-1:0] last_index = count_width'(PAYLOAD_BYTES + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_gap,
        st_finish
    } sender_state_t;

    sender_state_t            state;
    logic [count_width-1:0]   count;
    logic [payload_width-1:0] payload_q;
    link_byte_t               checksum;
    link_byte_t               cur_byte;
    logic                     fire;

    // A byte leaves only when the UART is free
    assign fire = (state == st_issue) && !uart_busy;

    // ==================================================
    // Byte selection
    // ==================================================
    always_comb begin
        if (count == '0) begin
            cur_byte = FRAME_ID;
        end else if (count == last_index) begin
            cur_byte = checksum;
        end else begin
            // Payload copy shifts up, so the next byte is always on top
            cur_byte = payload_q[payload_width-1 -: 8];
        end
    end

    // ==================================================
    // Sequencing
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (port.send) begin
                        state <= st_issue;
                        count <= '0;
                    end
                end
                st_issue: begin
                    if (!uart_busy) begin
                        if (count == last_index) begin
                            state <= st_finish;
                        end else begin
                            count <= count + 1'b1;
                            state <= st_gap;
                        end
                    end
                end
                // Quiet cycle so the UART can raise busy
                st_gap: begin
                    state <= st_issue;
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Payload copy and running checksum
    always_ff @(posedge clock) begin
        if ((state == st_idle) && port.send) begin
            payload_q <= payload;
            checksum  <= '0;
        end else if (fire) begin
            checksum <= checksum ^ cur_byte;
            if (count != '0) begin
                payload_q <= payload_q << 8;
            end
        end
    end

    assign port.tx_start = fire;
    assign port.tx_data  = cur_byte;
    assign port.done     = (state == st_finish);

endmodule

`default_nettype wire

// File: hw/link_controller/link_controller.sv
// Follows the game phase, starts the due frame sender and routes its bytes to the UART port
`timescale 1ns/1ns
`default_nettype none

module link_controller (
    input  logic                  clock,
    input  logic                  reset,
    input  game_pkg::game_state_t game_state,
    frame_if.ctrl                 setup_port,
    frame_if.ctrl                 status_port,
    frame_if.ctrl                 end_port,
    output logic                  tx_start,
    output link_pkg::link_byte_t  tx_data
);
    import game_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_send_setup,
        st_wait_setup,
        st_send_status,
        st_wait_status,
        st_send_end,
        st_wait_end,
        st_game_over
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        game_active;
    logic        game_ended;

    // Board is known once loading starts
    assign game_active = (game_state == state_loading) || (game_state == state_running);
    assign game_ended  = (game_state == state_victory) || (game_state == state_defeat);

    // ==================================================
    // Sequencing FSM
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (game_active) begin
                    next_state = st_send_setup;
                end
            end
            st_send_setup: begin
                next_state = st_wait_setup;
            end
            st_wait_setup: begin
                if (setup_port.done) begin
                    next_state = st_send_status;
                end
            end
            st_send_status: begin
                next_state = st_wait_status;
            end
            st_wait_status: begin
                // Status repeats until the game has an outcome
                if (status_port.done) begin
                    next_state = game_ended ? st_send_end : st_send_status;
                end
            end
            st_send_end: begin
                next_state = st_wait_end;
            end
            st_wait_end: begin
                if (end_port.done) begin
                    next_state = st_game_over;
                end
            end
            // Held until reset
            st_game_over: begin
                next_state = st_game_over;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // One-cycle start pulses
    assign setup_port.send  = (state == st_send_setup);
    assign status_port.send = (state == st_send_status);
    assign end_port.send    = (state == st_send_end);

    // ==================================================
    // UART port multiplexer
    // ==================================================
    always_comb begin
        case (state)
            st_wait_setup: begin
                tx_start = setup_port.tx_start;
                tx_data  = setup_port.tx_data;
            end
            st_wait_status: begin
                tx_start = status_port.tx_start;
                tx_data  = status_port.tx_data;
            end
            st_wait_end: begin
                tx_start = end_port.tx_start;
                tx_data  = end_port.tx_data;
            end
            default: begin
                tx_start = 1'b0;
                tx_data  = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/game_link_top.sv
// Telemetry top level, packs game fields into frame payloads and feeds one UART byte port
`timescale 1ns/1ns
`default_nettype none

module game_link_top (
    input  logic                  clock,
    input  logic                  reset,
    input  game_pkg::game_state_t game_state,
    input  logic                  difficulty,
    input  game_pkg::board_t      board,
    input  game_pkg::colors_t     colors,
    input  game_pkg::position_t   position,
    input  logic [1:0]            errors,
    input  logic [3:0]            selected_number,
    input  logic                  victory,
    input  game_pkg::score_t      score,
    input  game_pkg::seconds_t    seconds,
    input  logic                  uart_busy,
    output logic                  tx_start,
    output link_pkg::link_byte_t  tx_data
);
    import link_pkg::*;

    logic [setup_bytes*8-1:0]  setup_payload;
    logic [status_bytes*8-1:0] status_payload;
    logic [end_bytes*8-1:0]    end_payload;

    frame_if setup_if ();
    frame_if status_if ();
    frame_if end_if ();

    // ==================================================
    // Payload packing, most significant byte first
    // ==================================================

    // Difficulty byte, board padded by 4 bits
    assign setup_payload = {7'd0, difficulty, 4'd0, board};

    // Colors padded by 6 bits, position, errors and number
    assign status_payload = {6'd0, colors, position, 2'd0, errors, selected_number};

    // Victory with score, seconds padded by 5 bits
    assign end_payload = {victory, score, 5'd0, seconds};

    // ==================================================
    // Controller and senders
    // ==================================================
    link_controller u_link_controller (
        .clock       (clock),
        .reset       (reset),
        .game_state  (game_state),
        .setup_port  (setup_if.ctrl),
        .status_port (status_if.ctrl),
        .end_port    (end_if.ctrl),
        .tx_start    (tx_start),
        .tx_data     (tx_data)
    );

    frame_sender #(
        .FRAME_ID      (frame_id_setup),
        .PAYLOAD_BYTES (setup_bytes)
    ) u_setup_sender (
        .clock     (clock),
        .reset     (reset),
        .uart_busy (uart_busy),
        .payload   (setup_payload),
        .port      (setup_if.sender)
    );

    frame_sender #(
        .FRAME_ID      (frame_id_status),
        .PAYLOAD_BYTES (status_bytes)
    ) u_status_sender (
        .clock     (clock),
        .reset     (reset),
        .uart_busy (uart_busy),
        .payload   (status_payload),
        .port      (status_if.sender)
    );

    frame_sender #(
        .FRAME_ID      (frame_id_end),
        .PAYLOAD_BYTES (end_bytes)
    ) u_end_sender (
        .clock     (clock),
        .reset     (reset),
        .uart_busy (uart_busy),
        .payload   (end_payload),
        .port      (end_if.sender)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source, reset is applied again on each rising edge of reset_request
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 16
) (
    input  logic reset_request,
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

    // Reset counts rising edges and is released on a falling edge
    initial begin
        reset = 1'b1;
        forever begin
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;
            @(posedge reset_request);
            @(negedge clock);
            reset = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verif/game_link_assertions.sv
// Protocol checks on the UART byte port that are bound into the telemetry top level
`timescale 1ns/1ns
`default_nettype none

module game_link_assertions (
    input logic clock,
    input logic reset,
    input logic uart_busy,
    input logic tx_start
);

    // Count of failed protocol checks
    int failures = 0;

    // A byte may only be offered while the UART is free
    no_start_while_busy: assert property (
        @(posedge clock) disable iff (reset) tx_start |-> !uart_busy
    ) else begin
        failures++;
        $error("tx_start raised while uart_busy was high");
    end

    // Each byte request is a single-cycle strobe
    single_cycle_start: assert property (
        @(posedge clock) disable iff (reset) tx_start |=> !tx_start
    ) else begin
        failures++;
        $error("tx_start held for more than one cycle");
    end

    // Port stays quiet while reset is applied
    quiet_in_reset: assert property (
        @(posedge clock) reset |-> !tx_start
    ) else begin
        failures++;
        $error("tx_start raised during reset");
    end

endmodule

bind game_link_top game_link_assertions u_game_link_assertions (
    .clock     (clock),
    .reset     (reset),
    .uart_busy (uart_busy),
    .tx_start  (tx_start)
);

`default_nettype wire

// File: verif/game_link_tb.sv
// Testbench for the telemetry link that drives game phases and checks every frame on the UART port
`timescale 1ns/1ns
`default_nettype none

module game_link_tb;
    import game_pkg::*;
    import link_pkg::*;

    localparam int byte_timeout = 200;

    logic        clock;
    logic        reset;
    logic        reset_request;
    game_state_t game_state;
    logic        difficulty;
    board_t      board;
    colors_t     colors;
    position_t   position;
    logic [1:0]  errors;
    logic [3:0]  selected_number;
    logic        victory;
    score_t      score;
    seconds_t    seconds;
    logic        uart_busy;
    logic        tx_start;
    link_byte_t  tx_data;

    link_byte_t exp_frame [0:63];
    int         exp_len;
    int         error_count;
    int         test_errors;
    int         tests_run;
    int         tests_failed;
    int         stall_max;
    integer     field_seed;
    integer     busy_seed;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (16)
    ) u_clock_gen (
        .reset_request (reset_request),
        .clock         (clock),
        .reset         (reset)
    );

    game_link_top u_game_link_top (
        .clock           (clock),
        .reset           (reset),
        .game_state      (game_state),
        .difficulty      (difficulty),
        .board           (board),
        .colors          (colors),
        .position        (position),
        .errors          (errors),
        .selected_number (selected_number),
        .victory         (victory),
        .score           (score),
        .seconds         (seconds),
        .uart_busy       (uart_busy),
        .tx_start        (tx_start),
        .tx_data         (tx_data)
    );

    // UART model holds busy for a random number of cycles after every byte
    initial begin
        logic [31:0] r;
        int          hold;
        uart_busy = 1'b0;
        forever begin
            @(posedge clock);
            if (tx_start) begin
                r = $random(busy_seed);
                hold = 1 + int'(r[15:0]) % stall_max;
                @(negedge clock);
                uart_busy = 1'b1;
                repeat (hold) @(negedge clock);
                uart_busy = 1'b0;
            end
        end
    end

    // ==================================================
    // Expected frames
    // ==================================================
    function automatic void push_byte(input link_byte_t value);
        exp_frame[exp_len] = value;
        exp_len++;
    endfunction

    // Pushes the low count bytes of value with the most significant first
    function automatic void push_bytes(input logic [327:0] value, input int count);
        for (int k = count - 1; k >= 0; k--) begin
            push_byte(value[k*8 +: 8]);
        end
    endfunction

    function automatic void push_checksum();
        link_byte_t sum;
        sum = '0;
        for (int k = 0; k < exp_len; k++) begin
            sum = sum ^ exp_frame[k];
        end
        push_byte(sum);
    endfunction

    function automatic void build_setup_frame();
        exp_len = 0;
        push_byte(frame_id_setup);
        push_byte({7'd0, difficulty});
        push_bytes({4'd0, board}, 41);
        push_checksum();
    endfunction

    function automatic void build_status_frame();
        exp_len = 0;
        push_byte(frame_id_status);
        push_bytes({166'd0, colors}, 21);
        push_byte(position);
        push_byte({2'b00, errors, selected_number});
        push_checksum();
    endfunction

    function automatic void build_end_frame();
        exp_len = 0;
        push_byte(frame_id_end);
        push_byte({victory, score});
        push_bytes({317'd0, seconds}, 2);
        push_checksum();
    endfunction

    // ==================================================
    // Stimulus and collection
    // ==================================================
    task automatic randomize_fields();
        logic [31:0] r;
        for (int c = 0; c < 81; c++) begin
            r = $random(field_seed);
            board[c*4 +: 4]  = r[3:0];
            colors[c*2 +: 2] = r[9:8];
        end
        r = $random(field_seed);
        difficulty      = r[0];
        errors          = r[2:1];
        selected_number = r[6:3];
        position        = r[15:8];
        score           = r[22:16];
        r = $random(field_seed);
        seconds = r[10:0];
    endtask

    task automatic wait_for_byte(input int limit, output bit seen, output link_byte_t data);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        data = '0;
        while (!seen && cycles < limit) begin
            @(posedge clock);
            seen = tx_start;
            data = tx_data;
            cycles++;
        end
    endtask

    // Collects one frame and compares it byte by byte
    task automatic expect_frame(input string name);
        bit         seen;
        link_byte_t data;
        for (int i = 0; i < exp_len; i++) begin
            wait_for_byte(byte_timeout, seen, data);
            if (!seen) begin
                $display("Timeout: byte %0d of the %s frame did not arrive within %0d cycles",
                         i, name, byte_timeout);
                error_count++;
                return;
            end
            assert (data == exp_frame[i]) else begin
                $display("FAILED at %0t ns: tx_data (%s byte %0d) expected %02h got %02h",
                         $time, name, i, exp_frame[i], data);
                error_count++;
            end
        end
    endtask

    task automatic watch_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            assert (tx_start == 1'b0) else begin
                $display("FAILED at %0t ns: tx_start expected 0 got %b", $time, tx_start);
                error_count++;
            end
        end
    endtask

    task automatic wait_reset_level(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (reset !== level && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (reset !== level) begin
            $display("Timeout: reset did not reach %b within %0d cycles", level, limit);
            error_count++;
        end
    endtask

    task automatic restart_dut();
        @(negedge clock);
        reset_request = 1'b1;
        game_state = state_start;
        wait_reset_level(1'b1, 20);
        reset_request = 1'b0;
        wait_reset_level(1'b0, 40);
    endtask

    function automatic void report_test(input string name);
        tests_run++;
        if (error_count == test_errors) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endfunction

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        field_seed = 32'h8485;
        busy_seed = 32'h8485;
        stall_max = 6;
        error_count = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        reset_request = 1'b0;
        game_state = state_start;
        difficulty = 1'b0;
        board = '0;
        colors = '0;
        position = '0;
        errors = '0;
        selected_number = '0;
        victory = 1'b0;
        score = '0;
        seconds = '0;
        wait_reset_level(1'b0, 40);

        watch_quiet(100);
        @(negedge clock);
        game_state = state_select;
        watch_quiet(100);
        report_test("reset_idle");

        @(negedge clock);
        randomize_fields();
        game_state = state_loading;
        build_setup_frame();
        expect_frame("setup");
        report_test("setup_frame");

        // First status frame still carries the fields of the setup test
        @(negedge clock);
        game_state = state_running;
        build_status_frame();
        expect_frame("status");
        repeat (3) begin
            @(negedge clock);
            randomize_fields();
            build_status_frame();
            expect_frame("status");
        end
        report_test("status_frames");

        stall_max = 40;
        repeat (2) begin
            @(negedge clock);
            randomize_fields();
            build_status_frame();
            expect_frame("status");
        end
        stall_max = 6;
        report_test("back_pressure");

        @(negedge clock);
        randomize_fields();
        build_status_frame();
        expect_frame("status");
        @(negedge clock);
        victory = 1'b1;
        game_state = state_victory;
        build_end_frame();
        expect_frame("end");
        watch_quiet(300);
        report_test("end_victory");

        restart_dut();
        @(negedge clock);
        randomize_fields();
        game_state = state_loading;
        build_setup_frame();
        expect_frame("setup");
        build_status_frame();
        expect_frame("status");
        @(negedge clock);
        victory = 1'b0;
        game_state = state_defeat;
        build_end_frame();
        expect_frame("end");
        watch_quiet(300);
        report_test("end_defeat");

        if (u_game_link_top.u_game_link_assertions.failures != 0) begin
            $display("Protocol assertions on the UART port failed %0d times",
                     u_game_link_top.u_game_link_assertions.failures);
            error_count += u_game_link_top.u_game_link_assertions.failures;
        end

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
common/game_pkg.sv
common/link_pkg.sv
common/frame_if.sv
hw/frame_sender/frame_sender.sv
hw/link_controller/link_controller.sv
hw/game_link_top.sv
verif/tb_clock_gen.sv
verif/game_link_assertions.sv
verif/game_link_tb.sv

// File: Makefile
# Verilator build and run of the telemetry link testbench

VERILATOR ?= verilator
TOP       ?= game_link_tb
FILE_LIST ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
